// File: src/lane_defines.svh
`ifndef LANE_DEFINES_SVH
`define LANE_DEFINES_SVH

// Register file geometry
`define VL_WORD_W      32
`define VL_BYTES       4
`define VL_VRF_DEPTH   512
`define VL_VRF_AW      9

// Mask file geometry
`define VL_MASK_DEPTH  32
`define VL_MASK_AW     5

// ALU control code and pipe depths
`define VL_CTRL_W      6
`define VL_READ_DELAY  2
`define VL_WB_DELAY    2

`endif

// File: src/lane_pkg.sv
`default_nettype none

package lane_pkg;

   //////////////////////////////////////////////////
   // Element width
   //////////////////////////////////////////////////

   // Code 3 is not a legal width and reads as a zero element
   typedef enum logic [1:0] {
      SEW_8  = 2'd0,
      SEW_16 = 2'd1,
      SEW_32 = 2'd2
   } sew_e;

   //////////////////////////////////////////////////
   // Write data source
   //////////////////////////////////////////////////

   typedef enum logic {
      WB_SRC_ALU  = 1'b0,
      WB_SRC_LOAD = 1'b1
   } wb_src_e;

endpackage

`default_nettype wire

// File: src/lane_vrf.sv
`timescale 1ns/1ps
`default_nettype none

`include "lane_defines.svh"

module lane_vrf
   import lane_pkg::*;
(
   input  wire logic                      clk_i,
   input  wire logic                      rst_i,
   // Read issue
   input  wire logic                      ren_i,
   input  wire logic [`VL_VRF_AW-1:0]     raddr_a_i,
   input  wire logic [`VL_VRF_AW-1:0]     raddr_b_i,
   input  wire logic [1:0]                el_index_a_i,
   input  wire logic [1:0]                el_index_b_i,
   input  wire sew_e                      sew_i,
   input  wire logic [`VL_CTRL_W-1:0]     ctrl_i,
   input  wire logic                      rd_valid_i,
   // Write commit
   input  wire logic [`VL_VRF_AW-1:0]     we_addr_i,
   input  wire logic [`VL_WORD_W-1:0]     we_data_i,
   input  wire logic [`VL_BYTES-1:0]      we_bwen_i,
   // Operands and sideband to the ALU
   output logic [`VL_WORD_W-1:0]          vs1_o,
   output logic [`VL_WORD_W-1:0]          vs2_o,
   output logic [`VL_CTRL_W-1:0]          opmode_o,
   output sew_e                           sew_o,
   output logic                           vld_o
);

   // Storage starts out cleared
   logic [`VL_WORD_W-1:0] mem [`VL_VRF_DEPTH] = '{default: '0};

   // Raw words from the first read stage
   logic [`VL_WORD_W-1:0] word_a_q;
   logic [`VL_WORD_W-1:0] word_b_q;

   // Extracted elements
   logic [`VL_WORD_W-1:0] el_a_q;
   logic [`VL_WORD_W-1:0] el_b_q;

   // Sideband shift pipe
   sew_e                      sew_q  [`VL_READ_DELAY];
   logic [`VL_CTRL_W-1:0]     ctrl_q [`VL_READ_DELAY];
   logic [`VL_READ_DELAY-1:0] vld_q;
   logic [1:0]                idx_a_q;
   logic [1:0]                idx_b_q;

   // Pick one element out of a word and zero-extend it
   function automatic logic [`VL_WORD_W-1:0] extract_el(
      input logic [`VL_WORD_W-1:0] word,
      input logic [1:0]            idx,
      input sew_e                  sew
   );
      logic [`VL_WORD_W-1:0] el;
      el = '0;
      case (sew)
         SEW_8:   el[7:0]  = word[idx*8 +: 8];
         SEW_16:  el[15:0] = word[idx[0]*16 +: 16];
         SEW_32:  el       = word;
         default: el       = '0;
      endcase
      return el;
   endfunction

   //////////////////////////////////////////////////
   // Write port
   //////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      for (int b = 0; b < `VL_BYTES; b++) begin
         if (we_bwen_i[b]) begin
            mem[we_addr_i][b*8 +: 8] <= we_data_i[b*8 +: 8];
         end
      end
   end

   //////////////////////////////////////////////////
   // Read ports
   //////////////////////////////////////////////////

   // Same-edge write to the same word leaves the old word here
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         word_a_q <= '0;
         word_b_q <= '0;
      end else if (ren_i) begin
         word_a_q <= mem[raddr_a_i];
         word_b_q <= mem[raddr_b_i];
      end
   end

   // Element select uses the width and index of the same issue
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         el_a_q <= '0;
         el_b_q <= '0;
      end else begin
         el_a_q <= extract_el(word_a_q, idx_a_q, sew_q[0]);
         el_b_q <= extract_el(word_b_q, idx_b_q, sew_q[0]);
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         for (int s = 0; s < `VL_READ_DELAY; s++) begin
            sew_q[s]  <= SEW_8;
            ctrl_q[s] <= '0;
         end
         vld_q   <= '0;
         idx_a_q <= '0;
         idx_b_q <= '0;
      end else begin
         sew_q[0]  <= sew_i;
         ctrl_q[0] <= ctrl_i;
         for (int s = 1; s < `VL_READ_DELAY; s++) begin
            sew_q[s]  <= sew_q[s-1];
            ctrl_q[s] <= ctrl_q[s-1];
         end
         vld_q   <= {vld_q[`VL_READ_DELAY-2:0], rd_valid_i};
         idx_a_q <= el_index_a_i;
         idx_b_q <= el_index_b_i;
      end
   end

   assign vs1_o    = el_a_q;
   assign vs2_o    = el_b_q;
   assign opmode_o = ctrl_q[`VL_READ_DELAY-1];
   assign sew_o    = sew_q[`VL_READ_DELAY-1];
   assign vld_o    = vld_q[`VL_READ_DELAY-1];

   // Valid operands never carry the illegal width code
   a_sew_legal: assert property (@(posedge clk_i) disable iff (!rst_i)
      vld_o |-> (2'(sew_o) != 2'b11));

endmodule

`default_nettype wire

// File: src/lane_mask_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "lane_defines.svh"

module lane_mask_file (
   input  wire logic                     clk_i,
   input  wire logic                     rst_i,
   // Read side
   input  wire logic [`VL_MASK_AW-1:0]   raddr_i,
   // Commit from write-back
   input  wire logic                     wen_i,
   input  wire logic [`VL_MASK_AW-1:0]   waddr_i,
   input  wire logic                     wdata_i,
   output logic                          mask_bit_o
);

   // One mask bit per element, cleared at load time
   logic [`VL_MASK_DEPTH-1:0] mem = '0;

   logic [`VL_MASK_AW-1:0] raddr_q;
   logic                   bit_q;

   //////////////////////////////////////////////////
   // Write port
   //////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (wen_i) begin
         mem[waddr_i] <= wdata_i;
      end
   end

   //////////////////////////////////////////////////
   // Read port
   //////////////////////////////////////////////////

   // First stage holds the address
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         raddr_q <= '0;
      end else begin
         raddr_q <= raddr_i;
      end
   end

   // Second stage holds the stored bit
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         bit_q <= 1'b0;
      end else begin
         bit_q <= mem[raddr_q];
      end
   end

   assign mask_bit_o = bit_q;

   // Committed mask writes carry a known address and bit
   a_waddr_range: assert property (@(posedge clk_i) disable iff (!rst_i)
      wen_i |-> !$isunknown({waddr_i, wdata_i}));

endmodule

`default_nettype wire

// File: src/lane_writeback.sv
`timescale 1ns/1ps
`default_nettype none

`include "lane_defines.svh"

module lane_writeback
   import lane_pkg::*;
(
   input  wire logic                      clk_i,
   input  wire logic                      rst_i,
   // Write issue
   input  wire logic [`VL_VRF_AW-1:0]     waddr_i,
   input  wire logic [`VL_BYTES-1:0]      bwen_i,
   input  wire wb_src_e                   wdata_sel_i,
   input  wire logic [`VL_WORD_W-1:0]     load_data_i,
   input  wire logic [`VL_WORD_W-1:0]     alu_res_i,
   input  wire logic                      alu_vld_i,
   input  wire logic                      request_control_i,
   input  wire logic                      vector_mask_i,
   input  wire logic [`VL_MASK_AW-1:0]    vmrf_addr_i,
   input  wire logic                      vmrf_wen_i,
   input  wire logic                      alu_mask_i,
   // Mask bit read for this write
   input  wire logic                      mask_bit_i,
   // Register file commit
   output logic [`VL_VRF_AW-1:0]          vrf_waddr_o,
   output logic [`VL_WORD_W-1:0]          vrf_wdata_o,
   output logic [`VL_BYTES-1:0]           vrf_bwen_o,
   // Mask file commit
   output logic                           vmrf_wen_o,
   output logic [`VL_MASK_AW-1:0]         vmrf_waddr_o,
   output logic                           vmrf_wdata_o
);

   localparam int LAST = `VL_WB_DELAY - 1;

   logic [`VL_WORD_W-1:0]  wdata_sel;

   // Write pipe, one entry per stage
   logic [`VL_VRF_AW-1:0]  waddr_q [`VL_WB_DELAY];
   logic [`VL_WORD_W-1:0]  wdata_q [`VL_WB_DELAY];
   logic [`VL_BYTES-1:0]   bwen_q  [`VL_WB_DELAY];
   logic [`VL_MASK_AW-1:0] maddr_q [`VL_WB_DELAY];
   logic [`VL_WB_DELAY-1:0] vm_q;
   logic [`VL_WB_DELAY-1:0] en_q;
   logic [`VL_WB_DELAY-1:0] mwen_q;
   logic [`VL_WB_DELAY-1:0] mdata_q;

   logic [`VL_BYTES-1:0]   bwen_masked;

   // Source select at issue
   assign wdata_sel = (wdata_sel_i == WB_SRC_LOAD) ? load_data_i : alu_res_i;

   //////////////////////////////////////////////////
   // Pipe stages
   //////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         for (int s = 0; s < `VL_WB_DELAY; s++) begin
            waddr_q[s] <= '0;
            wdata_q[s] <= '0;
            bwen_q[s]  <= '0;
            maddr_q[s] <= '0;
         end
         vm_q    <= '0;
         en_q    <= '0;
         mwen_q  <= '0;
         mdata_q <= '0;
      end else begin
         waddr_q[0] <= waddr_i;
         wdata_q[0] <= wdata_sel;
         bwen_q[0]  <= bwen_i;
         maddr_q[0] <= vmrf_addr_i;
         for (int s = 1; s < `VL_WB_DELAY; s++) begin
            waddr_q[s] <= waddr_q[s-1];
            wdata_q[s] <= wdata_q[s-1];
            bwen_q[s]  <= bwen_q[s-1];
            maddr_q[s] <= maddr_q[s-1];
         end
         vm_q    <= {vm_q[LAST-1:0], vector_mask_i};
         en_q    <= {en_q[LAST-1:0], alu_vld_i | request_control_i};
         mwen_q  <= {mwen_q[LAST-1:0], vmrf_wen_i};
         mdata_q <= {mdata_q[LAST-1:0], alu_mask_i};
      end
   end

   //////////////////////////////////////////////////
   // Commit
   //////////////////////////////////////////////////

   // Masked writes keep only lanes whose mask bit is set
   assign bwen_masked = vm_q[LAST] ? (bwen_q[LAST] & {`VL_BYTES{mask_bit_i}}) : bwen_q[LAST];

   assign vrf_waddr_o  = waddr_q[LAST];
   assign vrf_wdata_o  = wdata_q[LAST];
   assign vrf_bwen_o   = bwen_masked & {`VL_BYTES{en_q[LAST]}};
   assign vmrf_wen_o   = mwen_q[LAST] & en_q[LAST];
   assign vmrf_waddr_o = maddr_q[LAST];
   assign vmrf_wdata_o = mdata_q[LAST];

   // Nothing reaches the register file from a disabled issue
   a_bwen_idle: assert property (@(posedge clk_i) disable iff (!rst_i)
      !$past(alu_vld_i | request_control_i, `VL_WB_DELAY) |-> (vrf_bwen_o == '0));

endmodule

`default_nettype wire

// File: src/vector_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "lane_defines.svh"

module vector_lane
   import lane_pkg::*;
(
   input  wire logic                      clk_i,
   input  wire logic                      rst_i,
   // Read issue
   input  wire logic                      vrf_ren_i,
   input  wire logic [`VL_VRF_AW-1:0]     vrf_raddr_a_i,
   input  wire logic [`VL_VRF_AW-1:0]     vrf_raddr_b_i,
   input  wire logic [1:0]                el_index_a_i,
   input  wire logic [1:0]                el_index_b_i,
   input  wire logic [1:0]                vsew_i,
   input  wire logic [`VL_CTRL_W-1:0]     alu_ctrl_i,
   input  wire logic                      read_data_valid_i,
   // Write issue
   input  wire logic [`VL_VRF_AW-1:0]     vrf_waddr_i,
   input  wire logic [`VL_BYTES-1:0]      vrf_bwen_i,
   input  wire logic                      wdata_sel_i,
   input  wire logic [`VL_WORD_W-1:0]     load_data_i,
   input  wire logic                      vector_mask_i,
   input  wire logic [`VL_MASK_AW-1:0]    vmrf_addr_i,
   input  wire logic                      vmrf_wen_i,
   input  wire logic [`VL_WORD_W-1:0]     alu_res_i,
   input  wire logic                      alu_vld_i,
   input  wire logic                      alu_mask_i,
   input  wire logic                      request_control_i,
   // ALU side
   output logic [`VL_WORD_W-1:0]          vs1_data_o,
   output logic [`VL_WORD_W-1:0]          vs2_data_o,
   output logic [`VL_CTRL_W-1:0]          alu_opmode_o,
   output logic [1:0]                     alu_read_sew_o,
   output logic                           alu_vld_o
);

   // Register file commit
   logic [`VL_VRF_AW-1:0]  vrf_waddr;
   logic [`VL_WORD_W-1:0]  vrf_wdata;
   logic [`VL_BYTES-1:0]   vrf_bwen;

   // Mask path
   logic                   mask_bit;
   logic                   vmrf_wen;
   logic [`VL_MASK_AW-1:0] vmrf_waddr;
   logic                   vmrf_wdata;

   sew_e                   read_sew;

   //////////////////////////////////////////////////
   // Register file and operand extraction
   //////////////////////////////////////////////////

   lane_vrf u_vrf (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .ren_i        (vrf_ren_i),
      .raddr_a_i    (vrf_raddr_a_i),
      .raddr_b_i    (vrf_raddr_b_i),
      .el_index_a_i (el_index_a_i),
      .el_index_b_i (el_index_b_i),
      .sew_i        (sew_e'(vsew_i)),
      .ctrl_i       (alu_ctrl_i),
      .rd_valid_i   (read_data_valid_i),
      .we_addr_i    (vrf_waddr),
      .we_data_i    (vrf_wdata),
      .we_bwen_i    (vrf_bwen),
      .vs1_o        (vs1_data_o),
      .vs2_o        (vs2_data_o),
      .opmode_o     (alu_opmode_o),
      .sew_o        (read_sew),
      .vld_o        (alu_vld_o)
   );

   assign alu_read_sew_o = read_sew;

   //////////////////////////////////////////////////
   // Mask file
   //////////////////////////////////////////////////

   lane_mask_file u_mask_file (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .raddr_i    (vmrf_addr_i),
      .wen_i      (vmrf_wen),
      .waddr_i    (vmrf_waddr),
      .wdata_i    (vmrf_wdata),
      .mask_bit_o (mask_bit)
   );

   //////////////////////////////////////////////////
   // Write-back
   //////////////////////////////////////////////////

   lane_writeback u_writeback (
      .clk_i             (clk_i),
      .rst_i             (rst_i),
      .waddr_i           (vrf_waddr_i),
      .bwen_i            (vrf_bwen_i),
      .wdata_sel_i       (wb_src_e'(wdata_sel_i)),
      .load_data_i       (load_data_i),
      .alu_res_i         (alu_res_i),
      .alu_vld_i         (alu_vld_i),
      .request_control_i (request_control_i),
      .vector_mask_i     (vector_mask_i),
      .vmrf_addr_i       (vmrf_addr_i),
      .vmrf_wen_i        (vmrf_wen_i),
      .alu_mask_i        (alu_mask_i),
      .mask_bit_i        (mask_bit),
      .vrf_waddr_o       (vrf_waddr),
      .vrf_wdata_o       (vrf_wdata),
      .vrf_bwen_o        (vrf_bwen),
      .vmrf_wen_o        (vmrf_wen),
      .vmrf_waddr_o      (vmrf_waddr),
      .vmrf_wdata_o      (vmrf_wdata)
   );

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
   output logic clk_o,
   output logic rst_o
);

   // 10 ns period
   initial begin
      clk_o = 1'b0;
      forever #5 clk_o = ~clk_o;
   end

   // Active-low reset held over three rising edges
   initial begin
      rst_o = 1'b0;
      repeat (3) @(posedge clk_o);
      rst_o <= 1'b1;
   end

endmodule

`default_nettype wire

// File: testbench/tb_vector_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "lane_defines.svh"

module tb_vector_lane
   import lane_pkg::*;
();

   localparam int AW          = `VL_VRF_AW;
   localparam int TEST_CYCLES = 500;
   localparam int NUM_TESTS   = 6;
   localparam int CYCLE_LIMIT = NUM_TESTS * TEST_CYCLES + 1000;

   typedef struct packed {
      logic [`VL_VRF_AW-1:0]  addr;
      logic [`VL_WORD_W-1:0]  data;
      logic [`VL_BYTES-1:0]   bwen;
      logic                   vm;
      logic                   en;
      logic                   mwen;
      logic [`VL_MASK_AW-1:0] maddr;
      logic                   mdata;
      logic                   mbit;
   } wr_t;

   typedef struct packed {
      logic [`VL_WORD_W-1:0] word_a;
      logic [`VL_WORD_W-1:0] word_b;
      logic [1:0]            idx_a;
      logic [1:0]            idx_b;
      logic [1:0]            sew;
      logic [`VL_CTRL_W-1:0] ctrl;
      logic                  vld;
   } rd_t;

   logic                   clk;
   logic                   rst;
   logic                   ren;
   logic [`VL_VRF_AW-1:0]  raddr_a;
   logic [`VL_VRF_AW-1:0]  raddr_b;
   logic [1:0]             idx_a;
   logic [1:0]             idx_b;
   logic [1:0]             vsew;
   logic [`VL_CTRL_W-1:0]  ctrl;
   logic                   rd_valid;
   logic [`VL_VRF_AW-1:0]  waddr;
   logic [`VL_BYTES-1:0]   bwen;
   logic                   wsel;
   logic [`VL_WORD_W-1:0]  load_data;
   logic [`VL_WORD_W-1:0]  alu_res;
   logic                   vm;
   logic                   alu_vld;
   logic                   req_ctrl;
   logic                   vmrf_wen;
   logic                   alu_mask;
   logic [`VL_MASK_AW-1:0] vmrf_addr;
   logic [`VL_WORD_W-1:0]  vs1;
   logic [`VL_WORD_W-1:0]  vs2;
   logic [`VL_CTRL_W-1:0]  opmode;
   logic [1:0]             read_sew;
   logic                   vld_out;

   // Reference model state
   logic [`VL_WORD_W-1:0]    ref_mem [`VL_VRF_DEPTH];
   logic [`VL_MASK_DEPTH-1:0] ref_mask;
   logic [`VL_WORD_W-1:0]    held_a;
   logic [`VL_WORD_W-1:0]    held_b;
   wr_t                      wr_pipe [2];
   rd_t                      rd_pipe [2];

   logic [31:0] lfsr_state = 32'h4b2b;
   int          cycle_count = 0;
   int          checks = 0;
   int          test_errors = 0;
   int          total_errors = 0;
   int          failed_tests = 0;

   tb_clock_gen u_clock_gen (
      .clk_o (clk),
      .rst_o (rst)
   );

   vector_lane dut (
      .clk_i             (clk),
      .rst_i             (rst),
      .vrf_ren_i         (ren),
      .vrf_raddr_a_i     (raddr_a),
      .vrf_raddr_b_i     (raddr_b),
      .el_index_a_i      (idx_a),
      .el_index_b_i      (idx_b),
      .vsew_i            (vsew),
      .alu_ctrl_i        (ctrl),
      .read_data_valid_i (rd_valid),
      .vrf_waddr_i       (waddr),
      .vrf_bwen_i        (bwen),
      .wdata_sel_i       (wsel),
      .load_data_i       (load_data),
      .vector_mask_i     (vm),
      .vmrf_addr_i       (vmrf_addr),
      .vmrf_wen_i        (vmrf_wen),
      .alu_res_i         (alu_res),
      .alu_vld_i         (alu_vld),
      .alu_mask_i        (alu_mask),
      .request_control_i (req_ctrl),
      .vs1_data_o        (vs1),
      .vs2_data_o        (vs2),
      .alu_opmode_o      (opmode),
      .alu_read_sew_o    (read_sew),
      .alu_vld_o         (vld_out)
   );

   //////////////////////////////////////////////////
   // Random source and expected values
   //////////////////////////////////////////////////

   // Fibonacci LFSR with taps 32 22 2 1, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      logic        fb;
      val = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         val = {val[30:0], fb};
      end
      return val;
   endfunction

   // Element k of a word sits at bit k times the element width
   function automatic logic [31:0] expect_el(input logic [31:0] word, input logic [1:0] idx,
                                              input logic [1:0] sew);
      case (sew)
         2'd0:    return (word >> (8 * idx)) & 32'h0000_00ff;
         2'd1:    return (word >> (16 * idx)) & 32'h0000_ffff;
         2'd2:    return word;
         default: return '0;
      endcase
   endfunction

   function automatic string test_name(input int t);
      case (t)
         1:       return "reset and unwritten";
         2:       return "full-word loads";
         3:       return "element extraction";
         4:       return "partial byte enables";
         5:       return "masked writes";
         default: return "ALU sideband";
      endcase
   endfunction

   //////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////

   task automatic commit_write(input wr_t w);
      if (w.en) begin
         for (int b = 0; b < `VL_BYTES; b++) begin
            if (w.bwen[b] && (!w.vm || w.mbit)) begin
               ref_mem[w.addr][b*8 +: 8] = w.data[b*8 +: 8];
            end
         end
         if (w.mwen) begin
            ref_mask[w.maddr] = w.mdata;
         end
      end
   endtask

   // One clock edge, reads and mask lookups see the state before commits
   task automatic model_edge();
      wr_t nw;
      rd_t nr;
      if (ren) begin
         held_a = ref_mem[raddr_a];
         held_b = ref_mem[raddr_b];
      end
      nr.word_a = held_a;
      nr.word_b = held_b;
      nr.idx_a  = idx_a;
      nr.idx_b  = idx_b;
      nr.sew    = vsew;
      nr.ctrl   = ctrl;
      nr.vld    = rd_valid;
      rd_pipe[1] = rd_pipe[0];
      rd_pipe[0] = nr;
      wr_pipe[0].mbit = ref_mask[wr_pipe[0].maddr];
      commit_write(wr_pipe[1]);
      wr_pipe[1] = wr_pipe[0];
      nw.addr  = waddr;
      nw.data  = (wsel == WB_SRC_LOAD) ? load_data : alu_res;
      nw.bwen  = bwen;
      nw.vm    = vm;
      nw.en    = alu_vld | req_ctrl;
      nw.mwen  = vmrf_wen;
      nw.maddr = vmrf_addr;
      nw.mdata = alu_mask;
      nw.mbit  = 1'b0;
      wr_pipe[0] = nw;
   endtask

   //////////////////////////////////////////////////
   // Stimulus and checks
   //////////////////////////////////////////////////

   task automatic drive_random(input int test);
      logic [1:0] sew;
      logic [1:0] ia;
      logic [1:0] ib;
      logic [1:0] en;
      sew = 2'(rand_bits(2));
      if (sew == 2'd3 || test == 2 || test == 4) sew = SEW_32;
      ia = 2'(rand_bits(2));
      ib = 2'(rand_bits(2));
      // Keep the index inside the word for the chosen width
      if (sew == SEW_16) begin
         ia[1] = 1'b0;
         ib[1] = 1'b0;
      end else if (sew == SEW_32) begin
         ia = 2'd0;
         ib = 2'd0;
      end
      en = 2'(rand_bits(2));
      if (test == 1) en = 2'b00;
      else if (test <= 4 && en == 2'b00) en = 2'b01;
      ren      <= (rand_bits(3) != 0);
      raddr_a  <= AW'(rand_bits(6));
      raddr_b  <= AW'(rand_bits(6));
      idx_a    <= ia;
      idx_b    <= ib;
      vsew     <= sew;
      ctrl     <= 6'(rand_bits(6));
      rd_valid <= 1'(rand_bits(1));
      alu_vld  <= en[0];
      req_ctrl <= en[1];
      waddr    <= AW'(rand_bits(6));
      bwen     <= (test == 2 || test == 3) ? 4'hf : 4'(rand_bits(4));
      if (test == 2) wsel <= WB_SRC_LOAD;
      else wsel <= 1'(rand_bits(1));
      load_data <= rand_bits(32);
      alu_res   <= rand_bits(32);
      vm        <= (test >= 5) ? 1'(rand_bits(1)) : 1'b0;
      vmrf_wen  <= (test >= 5) ? 1'(rand_bits(1)) : 1'b0;
      alu_mask  <= 1'(rand_bits(1));
      vmrf_addr <= 5'(rand_bits(5));
   endtask

   task automatic report_error(input string what, input logic [31:0] got,
                               input logic [31:0] want);
      $display("error at %0t ns: %s is %h, expected %h", $time, what, got, want);
      test_errors++;
   endtask

   // Outputs now belong to the issue two edges back
   task automatic check_outputs();
      rd_t         r;
      logic [31:0] exp_a;
      logic [31:0] exp_b;
      r = rd_pipe[1];
      exp_a = expect_el(r.word_a, r.idx_a, r.sew);
      exp_b = expect_el(r.word_b, r.idx_b, r.sew);
      checks++;
      if (vs1 !== exp_a) report_error("vs1_data_o", vs1, exp_a);
      if (vs2 !== exp_b) report_error("vs2_data_o", vs2, exp_b);
      if (opmode !== r.ctrl) report_error("alu_opmode_o", 32'(opmode), 32'(r.ctrl));
      if (read_sew !== r.sew) report_error("alu_read_sew_o", 32'(read_sew), 32'(r.sew));
      if (vld_out !== r.vld) report_error("alu_vld_o", 32'(vld_out), 32'(r.vld));
   endtask

   task automatic run_cycle(input int test);
      @(posedge clk);
      model_edge();
      drive_random(test);
      @(negedge clk);
      check_outputs();
   endtask

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Test failed");
         $finish;
      end
   end

   initial begin
      ren = 1'b0;
      raddr_a = '0;
      raddr_b = '0;
      idx_a = '0;
      idx_b = '0;
      vsew = '0;
      ctrl = '0;
      rd_valid = 1'b0;
      waddr = '0;
      bwen = '0;
      wsel = 1'b0;
      load_data = '0;
      alu_res = '0;
      vm = 1'b0;
      alu_vld = 1'b0;
      req_ctrl = 1'b0;
      vmrf_wen = 1'b0;
      alu_mask = 1'b0;
      vmrf_addr = '0;
      for (int i = 0; i < `VL_VRF_DEPTH; i++) begin
         ref_mem[i] = '0;
      end
      ref_mask = '0;
      held_a = '0;
      held_b = '0;
      wr_pipe[0] = '0;
      wr_pipe[1] = '0;
      rd_pipe[0] = '0;
      rd_pipe[1] = '0;
      wait (rst === 1'b1);
      @(negedge clk);
      for (int t = 1; t <= NUM_TESTS; t++) begin
         test_errors = 0;
         if (t == 1 && (vld_out !== 1'b0 || vs1 !== '0 || vs2 !== '0)) begin
            $display("error at %0t ns: outputs are not cleared after reset", $time);
            test_errors++;
         end
         for (int c = 0; c < TEST_CYCLES; c++) begin
            run_cycle(t);
         end
         $display("test %0d %-22s %0d cycles, %0d errors", t, test_name(t), TEST_CYCLES,
                  test_errors);
         total_errors += test_errors;
         if (test_errors != 0) failed_tests++;
      end
      $display("tests %0d, tests with errors %0d, cycles checked %0d, errors %0d",
               NUM_TESTS, failed_tests, checks, total_errors);
      if (total_errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
+incdir+src
src/lane_pkg.sv
src/lane_vrf.sv
src/lane_mask_file.sv
src/lane_writeback.sv
src/vector_lane.sv
testbench/tb_clock_gen.sv
testbench/tb_vector_lane.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = tb_vector_lane
FLIST = flist.f
BUILD = obj_dir
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
